// ==== sim.f ====
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/phase_ctrl.sv
verilog/exec_datapath.sv
verilog/mem_align.sv
verilog/rv_core.sv
verif/rv_core_assert.sv
verif/rv_core_tb.sv

// ==== verif/rv_core_tb.sv ====
// clock, reset, wait-state memory model, program table, test loop and report
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ;

	localparam word_t RES_ADDR  = 32'h0000_0100;
	localparam word_t DATA_ADDR = 32'h0000_0080;
	localparam word_t DATA_WORD = 32'h8c7e_f501;
	localparam word_t NOP       = 32'h0000_0013;
	localparam word_t OPA       = 32'hffff_f9c3; // -1597
	localparam word_t OPB       = 32'd13;
	localparam word_t STV       = 32'hffff_fa5b; // -1445

	logic  clk;
	logic  rst;
	logic  ready;
	word_t a;
	word_t d;
	word_t spo;
	logic  we;
	logic  rd;
	word_t mem [128];          // bus byte order
	logic  req;
	logic  served;
	int    wait_left;
	logic [31:0] lcg_state;
	logic  result_seen;
	word_t result_val;
	word_t prog_tab [64][8];
	word_t data_tab [64];
	word_t exp_tab [64];
	string name_tab [64];
	int    n_tests;
	int    errors;
	int    cycles;
	int    limit;

	rv_core u_rv_core (
		.clk   (clk),
		.rst   (rst),
		.a     (a),
		.d     (d),
		.we    (we),
		.rd    (rd),
		.spo   (spo),
		.ready (ready)
	);

	always #10 clk = !clk;

	assign spo = mem[a[8:2]];

	function automatic word_t swap_bytes(input word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic int next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state[31:16]);
	endfunction

	// memory model with 0 to 2 wait cycles per transfer
	always @(posedge clk) begin
		req    = (rd === 1'b1) || (we === 1'b1);
		served = ready;
		if (we === 1'b1 && served) begin
			mem[a[8:2]] <= d;
			if (a == RES_ADDR) begin
				result_val  <= swap_bytes(d);
				result_seen <= 1'b1;
			end
		end
		#1;
		if (rst)
			wait_left = 0;
		else if (req && served)
			wait_left = next_rand() % 3;
		else if (req && wait_left != 0)
			wait_left = wait_left - 1;
		ready = (wait_left == 0);
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("timeout: no result write after %0d cycles", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	// instruction encoders
	function automatic word_t i_type(input logic [2:0] f3, input int rd_i, input int rs1,
		input word_t imm, input logic [6:0] opc);
		return {imm[11:0], 5'(rs1), f3, 5'(rd_i), opc};
	endfunction

	function automatic word_t r_type(input logic alt, input logic [2:0] f3, input int rd_i,
		input int rs1, input int rs2);
		return {1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd_i), 7'b0110011};
	endfunction

	function automatic word_t s_type(input logic [2:0] f3, input int rs1, input int rs2,
		input word_t imm);
		return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t b_type(input logic [2:0] f3, input int rs1, input int rs2,
		input word_t imm);
		return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t j_type(input int rd_i, input word_t imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd_i), 7'b1101111};
	endfunction

	function automatic word_t addi(input int rd_i, input int rs1, input word_t imm);
		return i_type(3'b000, rd_i, rs1, imm, 7'b0010011);
	endfunction

	// RV32I rules for the expected values
	function automatic word_t expect_alu(input logic alt, input logic [2:0] f3,
		input word_t x, input word_t y);
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'b0, $signed(x) < $signed(y)};
			3'd3: return {31'b0, x < y};
			3'd4: return x ^ y;
			3'd5: return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input word_t x, input word_t y);
		case (f3)
			3'd0: return x == y;
			3'd1: return x != y;
			3'd4: return $signed(x) < $signed(y);
			3'd5: return $signed(x) >= $signed(y);
			3'd6: return x < y;
			default: return x >= y;
		endcase
	endfunction

	function automatic word_t expect_load(input logic [2:0] f3, input int off, input word_t w);
		word_t s;
		s = w >> (off * 8);
		case (f3)
			3'd0: return {{24{s[7]}}, s[7:0]};
			3'd4: return {24'b0, s[7:0]};
			3'd1: return {{16{s[15]}}, s[15:0]};
			3'd5: return {16'b0, s[15:0]};
			default: return w;
		endcase
	endfunction

	function automatic word_t expect_store(input logic [2:0] f3, input int off, input word_t w,
		input word_t v);
		word_t mask;
		mask = (f3 == 3'd0) ? 32'hff : ((f3 == 3'd1) ? 32'hffff : 32'hffff_ffff);
		mask = mask << (off * 8);
		return (w & ~mask) | ((v << (off * 8)) & mask);
	endfunction

	// result store and self-jump close every program
	task automatic add_test(input string name, input word_t i0, input word_t i1, input word_t i2,
		input word_t i3, input word_t i4, input word_t i5, input word_t expv);
		prog_tab[n_tests] = '{i0, i1, i2, i3, i4, i5, s_type(3'd2, 0, 10, RES_ADDR),
			j_type(0, 32'd0)};
		data_tab[n_tests] = DATA_WORD;
		exp_tab[n_tests]  = expv;
		name_tab[n_tests] = name;
		n_tests = n_tests + 1;
	endtask

	task automatic build_tests();
		logic [2:0] alu_f3 [10];
		logic       alu_alt [10];
		logic [2:0] br_f3 [6];
		word_t      bx [3];
		word_t      by [3];
		logic [2:0] ld_f3 [5];
		alu_f3  = '{3'd0, 3'd0, 3'd4, 3'd6, 3'd7, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
		alu_alt = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
		br_f3   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		bx      = '{32'hffff_fffb, 32'd3, 32'd3};
		by      = '{32'd3, 32'hffff_fffb, 32'd3};
		ld_f3   = '{3'd0, 3'd4, 3'd1, 3'd5, 3'd2};
		for (int i = 0; i < 10; i++)
			add_test($sformatf("alu f3=%0d alt=%0d", alu_f3[i], alu_alt[i]), addi(1, 0, OPA),
				addi(2, 0, OPB), r_type(alu_alt[i], alu_f3[i], 10, 1, 2), NOP, NOP, NOP,
				expect_alu(alu_alt[i], alu_f3[i], OPA, OPB));
		add_test("addi", addi(1, 0, OPA), addi(10, 1, 32'd500), NOP, NOP, NOP, NOP, OPA + 500);
		add_test("lui", {20'habcde, 5'd10, 7'b0110111}, NOP, NOP, NOP, NOP, NOP, 32'habcde000);
		add_test("auipc", NOP, {20'h00012, 5'd10, 7'b0010111}, NOP, NOP, NOP, NOP,
			32'd4 + 32'h12000);
		add_test("jal", j_type(10, 32'd24), addi(10, 0, 32'd99), NOP, NOP, NOP, NOP, 32'd4);
		// auipc at the landing word reports the exact target pc
		add_test("jalr", addi(1, 0, 32'd18), i_type(3'd0, 0, 1, 32'd3, 7'b1100111),
			addi(10, 0, 32'd1), j_type(0, 32'd12), NOP, {20'h0, 5'd10, 7'b0010111},
			(32'd18 + 32'd3) & ~32'd1);
		for (int k = 0; k < 6; k++)
			for (int p = 0; p < 3; p++)
				add_test($sformatf("branch f3=%0d pair %0d", br_f3[k], p), addi(1, 0, bx[p]),
					addi(2, 0, by[p]), b_type(br_f3[k], 1, 2, 32'd12), addi(10, 0, 32'd1),
					j_type(0, 32'd8), addi(10, 0, 32'd2),
					branch_taken(br_f3[k], bx[p], by[p]) ? 32'd2 : 32'd1);
		for (int k = 0; k < 5; k++)
			for (int off = 0; off < 4; off += (1 << ld_f3[k][1:0]))
				add_test($sformatf("load f3=%0d off=%0d", ld_f3[k], off),
					i_type(ld_f3[k], 10, 0, DATA_ADDR + off, 7'b0000011), NOP, NOP, NOP, NOP, NOP,
					expect_load(ld_f3[k], off, DATA_WORD));
		for (int k = 0; k < 3; k++)
			for (int off = 0; off < 4; off += (1 << k))
				add_test($sformatf("store f3=%0d off=%0d", k, off), addi(2, 0, STV),
					s_type(3'(k), 0, 2, DATA_ADDR + off),
					i_type(3'd2, 10, 0, DATA_ADDR, 7'b0000011), NOP, NOP, NOP,
					expect_store(3'(k), off, DATA_WORD, STV));
	endtask

	task automatic run_test(input int idx);
		@(posedge clk);
		#1 rst = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		for (int i = 0; i < 128; i++)
			mem[i] = {16'ha5c3, 16'(i * 4)} ^ 32'h1357_0000; // unused words
		for (int i = 0; i < 8; i++)
			mem[i] = swap_bytes(prog_tab[idx][i]);
		mem[DATA_ADDR[8:2]] = swap_bytes(data_tab[idx]);
		result_seen = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst = 1'b0;
		#1;
		assert (a === START_ADDR) else begin
			$display("[ERROR] %0t a: got %h expected %h", $time, a, START_ADDR);
			errors = errors + 1;
		end
		assert (rd === 1'b1) else begin
			$display("first fetch after reset did not raise rd");
			errors = errors + 1;
		end
		while (!result_seen) begin
			@(posedge clk);
			#2;
		end
		assert (result_val === exp_tab[idx]) else begin
			$display("[ERROR] %0t result_val: got %h expected %h", $time, result_val,
				exp_tab[idx]);
			errors = errors + 1;
		end
		$display("test %0d %s: %s", idx, name_tab[idx],
			(result_val === exp_tab[idx]) ? "ok" : "mismatch");
	endtask

	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		ready       = 1'b1;
		wait_left   = 0;
		lcg_state   = 32'h554a_ed78;
		result_seen = 1'b0;
		result_val  = '0;
		n_tests     = 0;
		errors      = 0;
		cycles      = 0;
		limit       = 0;
		build_tests();
		limit = n_tests * 400;
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		errors = errors + u_rv_core.u_rv_core_assert.fails; // bound assertion failures
		$display("tests run %0d, errors %0d", n_tests, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/rv_core_assert.sv ====
// bound checks for bus exclusivity, address alignment and memory wait exit
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert import rv_pkg::*; (
	input wire logic   clk,
	input wire logic   rst,
	input wire logic   rd,
	input wire logic   we,
	input wire word_t  a,
	input wire logic   ready,
	input wire phase_t phase
);

	int fails = 0;  // failed assertion count

	rd_we_exclusive: assert property (@(posedge clk) disable iff (rst) !(rd && we))
		else begin
			$error("rd and we high together");
			fails++;
		end

	addr_aligned: assert property (@(posedge clk) disable iff (rst) a[1:0] == 2'b00)
		else begin
			$error("bus address not word aligned");
			fails++;
		end

	// stay in the wait phase until the memory answers
	wait_held: assert property (@(posedge clk) disable iff (rst)
		(phase == PH_MEM_WAIT && !ready) |=> phase == PH_MEM_WAIT)
		else begin
			$error("left MEM_WAIT without ready");
			fails++;
		end

endmodule

bind rv_core rv_core_assert u_rv_core_assert (
	.clk   (clk),
	.rst   (rst),
	.rd    (rd),
	.we    (we),
	.a     (a),
	.ready (ready),
	.phase (u_phase_ctrl.phase)
);

`default_nettype wire

// ==== verilog/rv_core.sv ====
// rv_core: multicycle RV32I top level connecting decode, control, datapath and bus alignment
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	output word_t a,
	output word_t d,
	output logic  we,
	output logic  rd,
	input  word_t spo,
	input  logic  ready
);

	decoded_t dec;
	ctrl_t    ctrl;
	word_t    instr;
	word_t    mar;
	word_t    mdr;
	word_t    rs2_val;
	word_t    addr;
	word_t    wdata;
	word_t    bus_rdata;
	word_t    load_val;
	word_t    store_val;
	logic     br_taken;

	rv_decode u_rv_decode (
		.instr (instr),
		.dec   (dec)
	);

	phase_ctrl u_phase_ctrl (
		.clk      (clk),
		.rst      (rst),
		.dec      (dec),
		.ready    (ready),
		.br_taken (br_taken),
		.ctrl     (ctrl)
	);

	exec_datapath u_exec_datapath (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrl),
		.dec       (dec),
		.load_val  (load_val),
		.store_val (store_val),
		.bus_rdata (bus_rdata),
		.instr     (instr),
		.mar       (mar),
		.mdr       (mdr),
		.rs2_val   (rs2_val),
		.addr      (addr),
		.wdata     (wdata),
		.br_taken  (br_taken)
	);

	mem_align u_mem_align (
		.spo       (spo),
		.mem_data  (wdata),
		.mar       (mar),
		.mdr       (mdr),
		.rs2_val   (rs2_val),
		.dec       (dec),
		.ctrl      (ctrl),
		.bus_rdata (bus_rdata),
		.load_val  (load_val),
		.store_val (store_val),
		.d         (d)
	);

	assign a  = {addr[31:2], 2'b00}; // word access only
	assign rd = ctrl.mem_read;
	assign we = ctrl.mem_write;

endmodule

`default_nettype wire

// ==== verilog/mem_align.sv ====
// mem_align: bus byte reversal, load byte/half extraction, store byte/half merge
`timescale 1ns/1ps
`default_nettype none

module mem_align import rv_pkg::*; (
	input  word_t    spo,
	input  word_t    mem_data,
	input  word_t    mar,
	input  word_t    mdr,
	input  word_t    rs2_val,
	input  decoded_t dec,
	input  ctrl_t    ctrl,
	output word_t    bus_rdata,
	output word_t    load_val,
	output word_t    store_val,
	output word_t    d
);

	logic [7:0]  ld_byte;
	logic [15:0] ld_half;
	word_t       st_byte;
	word_t       st_half;
	logic        unsigned_ld;

	// bus byte 31:24 is little-endian byte 0
	function automatic word_t swap_bytes(input word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	assign bus_rdata   = swap_bytes(spo);
	assign d           = swap_bytes(mem_data);
	assign unsigned_ld = dec.funct3[2]; // LBU/LHU

	always_comb begin
		case (mar[1:0])
			2'b00: begin
				ld_byte = mdr[7:0];
				st_byte = {mdr[31:8], rs2_val[7:0]};
			end
			2'b01: begin
				ld_byte = mdr[15:8];
				st_byte = {mdr[31:16], rs2_val[7:0], mdr[7:0]};
			end
			2'b10: begin
				ld_byte = mdr[23:16];
				st_byte = {mdr[31:24], rs2_val[7:0], mdr[15:0]};
			end
			default: begin
				ld_byte = mdr[31:24];
				st_byte = {rs2_val[7:0], mdr[23:0]};
			end
		endcase
		if (mar[1]) begin
			ld_half = mdr[31:16];
			st_half = {rs2_val[15:0], mdr[15:0]};
		end else begin
			ld_half = mdr[15:0];
			st_half = {mdr[31:16], rs2_val[15:0]};
		end
	end

	always_comb begin
		case (ctrl.reg_src)
			RS_BYTE: load_val = unsigned_ld ? {24'b0, ld_byte} : {{24{ld_byte[7]}}, ld_byte};
			RS_HALF: load_val = unsigned_ld ? {16'b0, ld_half} : {{16{ld_half[15]}}, ld_half};
			default: load_val = mdr;
		endcase
		case (ctrl.mem_src)
			MS_BYTE: store_val = st_byte;
			MS_HALF: store_val = st_half;
			default: store_val = rs2_val; // SW
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/exec_datapath.sv ====
// exec_datapath: PC, IR, operand and memory registers, register file, ALU and datapath muxes
`timescale 1ns/1ps
`default_nettype none

module exec_datapath import rv_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  ctrl_t    ctrl,
	input  decoded_t dec,
	input  word_t    load_val,
	input  word_t    store_val,
	input  word_t    bus_rdata,
	output word_t    instr,
	output word_t    mar,
	output word_t    mdr,
	output word_t    rs2_val,
	output word_t    addr,
	output word_t    wdata,
	output logic     br_taken
);

	word_t pc;
	word_t a_reg;
	word_t b_reg;
	word_t alu_out;
	word_t alu_out_prev;  // branch target while compare runs
	word_t mwr;
	word_t rf_rd0;
	word_t rf_rd1;
	word_t alu_x;
	word_t alu_y;
	word_t alu_r;
	word_t wb_data;
	word_t next_pc;

	reg_file u_reg_file (
		.clk (clk),
		.ra0 (dec.rs1),
		.ra1 (dec.rs2),
		.wa  (dec.rd),
		.we  (ctrl.reg_write),
		.wd  (wb_data),
		.rd0 (rf_rd0),
		.rd1 (rf_rd1)
	);

	assign alu_x = ctrl.alu_a_pc ? pc : a_reg;
	assign alu_y = ctrl.alu_b_imm ? dec.imm : b_reg;

	alu u_alu (
		.op (ctrl.alu_op),
		.x  (alu_x),
		.y  (alu_y),
		.r  (alu_r)
	);

	always_comb begin
		case (ctrl.pc_src)
			PC_SEQ:    next_pc = pc + 32'd4;
			PC_BRANCH: next_pc = alu_out_prev;
			PC_JAL:    next_pc = alu_out;
			default:   next_pc = alu_out & ~32'd1; // jalr
		endcase
		case (ctrl.addr_src)
			ADDR_PC:  addr = pc;
			ADDR_ALU: addr = alu_out;
			default:  addr = mar;
		endcase
		case (ctrl.reg_src)
			RS_IMM:                   wb_data = dec.imm;
			RS_LINK:                  wb_data = pc;  // already advanced
			RS_BYTE, RS_HALF, RS_WORD: wb_data = load_val;
			default:                  wb_data = alu_out;
		endcase
	end

	assign wdata   = (ctrl.mem_src == MS_HELD) ? mwr : store_val;
	assign rs2_val = b_reg;

	// compare result sits in alu_out during WB
	assign br_taken = (dec.funct3[2] ? dec.funct3[0] : !dec.funct3[0]) ^ (|alu_out);

	always_ff @(posedge clk) begin
		if (rst)
			pc <= START_ADDR;
		else if (ctrl.pc_write)
			pc <= next_pc;
	end

	always_ff @(posedge clk) begin
		a_reg        <= rf_rd0;
		b_reg        <= rf_rd1;
		alu_out      <= alu_r;
		alu_out_prev <= alu_out;
		mar          <= addr;
		mwr          <= wdata;
		if (ctrl.mem_read)
			mdr <= bus_rdata;
		if (ctrl.ir_write)
			instr <= bus_rdata;
	end

endmodule

`default_nettype wire

// ==== verilog/phase_ctrl.sv ====
// phase_ctrl: multicycle phase FSM with memory wait return phase and control decode
`timescale 1ns/1ps
`default_nettype none

module phase_ctrl import rv_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  decoded_t dec,
	input  logic     ready,
	input  logic     br_taken,
	output ctrl_t    ctrl
);

	phase_t phase;
	phase_t phase_n;
	phase_t ret_phase;   // where MEM_WAIT goes when ready
	phase_t ret_n;
	logic   ret_set;

	// next phase
	always_comb begin
		phase_n = phase;
		ret_n   = ret_phase;
		ret_set = 1'b0;
		case (phase)
			PH_IF: begin
				if (ready) begin
					phase_n = PH_ID_RF;
				end else begin
					phase_n = PH_MEM_WAIT;
					ret_set = 1'b1;
					ret_n   = PH_ID_RF;
				end
			end
			PH_ID_RF: begin
				case (dec.opcode)
					OP_LUI, OP_AUIPC, OP_JAL:                   phase_n = PH_WB;
					OP_R, OP_R_I, OP_JALR, OP_BR, OP_LOAD, OP_STORE: phase_n = PH_EX;
					default:                                    phase_n = PH_IF; // fence, unknown
				endcase
			end
			PH_EX:
				phase_n = (dec.opcode == OP_LOAD || dec.opcode == OP_STORE) ? PH_MEM : PH_WB;
			PH_MEM: begin
				phase_n = PH_MEM_WAIT;
				ret_set = 1'b1;
				if (dec.opcode == OP_LOAD)
					ret_n = PH_WB;
				else if (dec.is_subword_store)
					ret_n = PH_EXU;  // read done, merge next
				else
					ret_n = PH_IF;
			end
			PH_EXU:
				phase_n = PH_MEMU;
			PH_MEMU: begin
				phase_n = PH_MEM_WAIT;
				ret_set = 1'b1;
				ret_n   = PH_IF;
			end
			PH_WB:
				phase_n = PH_IF;
			PH_MEM_WAIT:
				if (ready)
					phase_n = ret_phase;
			default:
				phase_n = PH_IF;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			phase     <= PH_IF;
			ret_phase <= PH_IF;
		end else begin
			phase <= phase_n;
			if (ret_set)
				ret_phase <= ret_n;
		end
	end

	// per-phase control
	always_comb begin
		ctrl          = '0;
		ctrl.pc_src   = PC_SEQ;
		ctrl.addr_src = ADDR_PC;
		ctrl.mem_src  = MS_WORD;
		ctrl.alu_op   = ALU_ADD;
		ctrl.reg_src  = RS_ALU;
		case (phase)
			PH_IF: begin
				ctrl.mem_read = 1'b1;
				ctrl.ir_write = 1'b1;
			end
			PH_ID_RF: begin
				ctrl.pc_write  = 1'b1;   // pc + 4
				ctrl.alu_a_pc  = 1'b1;   // branch / jal / auipc target
				ctrl.alu_b_imm = 1'b1;
			end
			PH_EX: begin
				case (dec.opcode)
					OP_R:
						ctrl.alu_op = alu_op_t'({dec.alt, dec.funct3});
					OP_R_I: begin
						// bit 30 is only an opcode bit for srai
						ctrl.alu_op    = alu_op_t'({dec.alt & (dec.funct3 == 3'b101), dec.funct3});
						ctrl.alu_b_imm = 1'b1;
					end
					OP_BR:
						ctrl.alu_op = dec.funct3[2] ? (dec.funct3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
					OP_JALR, OP_LOAD, OP_STORE:
						ctrl.alu_b_imm = 1'b1;
					default: ;
				endcase
			end
			PH_MEM: begin
				ctrl.addr_src = ADDR_ALU;
				if (dec.opcode == OP_LOAD || dec.is_subword_store)
					ctrl.mem_read = 1'b1;
				else if (dec.opcode == OP_STORE)
					ctrl.mem_write = 1'b1;
			end
			PH_EXU: begin
				ctrl.addr_src  = ADDR_HELD;
				ctrl.alu_b_imm = 1'b1;   // address again
			end
			PH_MEMU: begin
				ctrl.addr_src  = ADDR_ALU;
				ctrl.mem_write = 1'b1;
				ctrl.mem_src   = dec.funct3[0] ? MS_HALF : MS_BYTE;
			end
			PH_WB: begin
				case (dec.opcode)
					OP_R, OP_R_I, OP_AUIPC:
						ctrl.reg_write = 1'b1;
					OP_LUI: begin
						ctrl.reg_write = 1'b1;
						ctrl.reg_src   = RS_IMM;
					end
					OP_JAL, OP_JALR: begin
						ctrl.reg_write = 1'b1;
						ctrl.reg_src   = RS_LINK;
						ctrl.pc_write  = 1'b1;
						ctrl.pc_src    = (dec.opcode == OP_JAL) ? PC_JAL : PC_JALR;
					end
					OP_BR: begin
						ctrl.pc_write = br_taken;
						ctrl.pc_src   = PC_BRANCH;
					end
					OP_LOAD: begin
						ctrl.reg_write = 1'b1;
						ctrl.reg_src   = dec.funct3[1] ? RS_WORD : (dec.funct3[0] ? RS_HALF : RS_BYTE);
					end
					default: ;
				endcase
			end
			PH_MEM_WAIT: begin
				ctrl.addr_src  = ADDR_HELD;
				ctrl.mem_src   = MS_HELD;
				// only stores return straight to fetch
				ctrl.mem_read  = (ret_phase != PH_IF);
				ctrl.mem_write = (ret_phase == PH_IF);
				ctrl.ir_write  = ready && (ret_phase == PH_ID_RF);
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
// alu: RV32I add/sub, logic, shifts and set-less-than
`timescale 1ns/1ps
`default_nettype none

module alu import rv_pkg::*; (
	input  alu_op_t op,
	input  word_t   x,
	input  word_t   y,
	output word_t   r
);

	logic [4:0] shamt;

	assign shamt = y[4:0];

	always_comb begin
		case (op)
			ALU_ADD:  r = x + y;
			ALU_SUB:  r = x - y;
			ALU_SLL:  r = x << shamt;
			ALU_SLT:  r = {31'b0, $signed(x) < $signed(y)};
			ALU_SLTU: r = {31'b0, x < y};
			ALU_XOR:  r = x ^ y;
			ALU_SRL:  r = x >> shamt;
			ALU_SRA:  r = $signed(x) >>> shamt;
			ALU_OR:   r = x | y;
			ALU_AND:  r = x & y;
			default:  r = x + y;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
// reg_file: 32 x 32 register file, two async read ports, one sync write port, x0 fixed zero
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*; (
	input  logic      clk,
	input  reg_addr_t ra0,
	input  reg_addr_t ra1,
	input  reg_addr_t wa,
	input  logic      we,
	input  word_t     wd,
	output word_t     rd0,
	output word_t     rd1
);

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (we && wa != '0)
			regs[wa] <= wd;
	end

	assign rd0 = (ra0 == '0) ? '0 : regs[ra0];
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];

endmodule

`default_nettype wire

// ==== verilog/rv_decode.sv ====
// rv_decode: instruction field split and immediate generation
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_pkg::*; (
	input  word_t    instr,
	output decoded_t dec
);

	opcode_t op;
	word_t   imm_i;
	word_t   imm_s;
	word_t   imm_b;
	word_t   imm_u;
	word_t   imm_j;

	assign op = opcode_t'(instr[6:0]);

	assign imm_i = {{21{instr[31]}}, instr[30:20]};
	assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		dec.opcode = op;
		dec.rs1    = instr[19:15];
		dec.rs2    = instr[24:20];
		dec.rd     = instr[11:7];
		dec.funct3 = instr[14:12];
		dec.alt    = instr[30];
		// SW has bit 13 set, SB/SH do not
		dec.is_subword_store = (op == OP_STORE) && !instr[13];
		case (op)
			OP_LUI, OP_AUIPC:           dec.imm = imm_u;
			OP_R_I, OP_LOAD, OP_JALR:   dec.imm = imm_i;
			OP_BR:                      dec.imm = imm_b;
			OP_JAL:                     dec.imm = imm_j;
			OP_STORE:                   dec.imm = imm_s;
			default:                    dec.imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/rv_pkg.sv ====
// rv_pkg: widths, opcode/phase/alu enums, mux selects, decode and control structs, reset PC
`default_nettype none

package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// major opcodes, anything else is a no-op
	typedef enum logic [6:0] {
		OP_LUI   = 7'b0110111,
		OP_AUIPC = 7'b0010111,
		OP_JAL   = 7'b1101111,
		OP_JALR  = 7'b1100111,
		OP_BR    = 7'b1100011,
		OP_LOAD  = 7'b0000011,
		OP_STORE = 7'b0100011,
		OP_R_I   = 7'b0010011,
		OP_R     = 7'b0110011,
		OP_FENCE = 7'b0001111
	} opcode_t;

	typedef enum logic [3:0] {
		PH_IF, PH_ID_RF, PH_EX, PH_MEM, PH_EXU, PH_MEMU, PH_WB, PH_MEM_WAIT
	} phase_t;

	// {bit 30, funct3}
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_SRA  = 4'b1101
	} alu_op_t;

	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pc_src_t;
	typedef enum logic [1:0] {ADDR_PC, ADDR_ALU, ADDR_HELD} addr_src_t;
	typedef enum logic [2:0] {RS_ALU, RS_IMM, RS_LINK, RS_BYTE, RS_HALF, RS_WORD} reg_src_t;
	typedef enum logic [1:0] {MS_BYTE, MS_HALF, MS_WORD, MS_HELD} mem_src_t;

	typedef struct packed {
		opcode_t   opcode;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		logic [2:0] funct3;
		logic       alt;              // instr bit 30
		word_t      imm;
		logic       is_subword_store; // SB or SH
	} decoded_t;

	typedef struct packed {
		logic      pc_write;
		pc_src_t   pc_src;
		addr_src_t addr_src;
		logic      mem_read;
		logic      mem_write;
		mem_src_t  mem_src;
		logic      ir_write;
		alu_op_t   alu_op;
		logic      alu_a_pc;
		logic      alu_b_imm;
		logic      reg_write;
		reg_src_t  reg_src;
	} ctrl_t;

	localparam word_t START_ADDR = 32'h0000_0000;

endpackage

`default_nettype wire
